/* Makefile */
TOP := clic_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with verilator and run it"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --timescale 1ns/1ns -f build.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

/* bench/clic_tb.sv */
// clic testbench
`timescale 1ns/1ns

module clic_tb;
  import clic_pkg::*;

  localparam int vec_size = 8;
  localparam int clk_period = 20;
  localparam int reset_cycles = 3;
  localparam int csr_pairs = 150;
  localparam int arb_cycles = 300;
  localparam int mix_cycles = 400;
  localparam int nest_rounds = 10;
  localparam int total_cycles = reset_cycles + 2 * csr_pairs + 2 * vec_size + arb_cycles
                              + mix_cycles + vec_size + 3 * nest_rounds + 5;
  localparam logic [vec_size-1:0] top_irq = {1'b1, {(vec_size-1){1'b0}}};

  logic clk = 1'b0;
  logic rst_n;
  logic csr_enable;
  csr_addr_t csr_addr;
  csr_op_t csr_op;
  zimm_t rs1_zimm;
  csr_word_t rs1_data;
  logic [vec_size-1:0] irq;
  imem_addr_t pc_in;
  csr_word_t csr_out;
  imem_addr_t int_addr;
  pc_sel_t pc_interrupt_sel;
  level_t level_out;
  logic interrupt_out;

  // reference model state
  prio_t m_thresh;
  vec_word_t m_vec [vec_size];
  entry_t m_entry [vec_size];
  imem_addr_t m_stk_addr [stack_depth];
  prio_t m_stk_prio [stack_depth];
  level_t m_depth;
  logic [15:0] lfsr;

  clic_top #(.vec_size(vec_size)) uut (
    .clk, .rst_n, .csr_enable, .csr_addr, .csr_op, .rs1_zimm, .rs1_data, .irq, .pc_in,
    .csr_out, .int_addr, .pc_interrupt_sel, .level_out, .interrupt_out
  );

  always #(clk_period / 2) clk = ~clk;

  // fibonacci lfsr, taps 16 14 13 11
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic csr_addr_t rand_addr();
    logic [1:0] kind;
    kind = 2'(rand_bits(2));
    case (kind)
      2'd0: return int_thresh_addr;
      2'd1: return vec_csr_base + csr_addr_t'(rand_bits(4));
      2'd2: return entry_csr_base + csr_addr_t'(rand_bits(4));
      default: return csr_addr_t'(rand_bits(12));
    endcase
  endfunction

  function automatic csr_op_t rand_op();
    logic [1:0] v;
    v = 2'(rand_bits(2));
    return (v == 2'b00) ? csr_write : csr_op_t'(v);
  endfunction

  // never the return marker
  function automatic imem_addr_t rand_pc();
    imem_addr_t p;
    p = imem_addr_t'(rand_bits(16));
    return (p == '1) ? '0 : p;
  endfunction

  task automatic stop_fail(string why);
    $display("TEST FAIL");
    $fatal(1, "%s", why);
  endtask

  task automatic check_word(string name, csr_word_t exp, csr_word_t act);
    if (act !== exp) begin
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      stop_fail("value mismatch");
    end
  endtask

  task automatic check_addr(string name, imem_addr_t exp, imem_addr_t act);
    if (act !== exp) begin
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      stop_fail("value mismatch");
    end
  endtask

  task automatic check_level(string name, level_t exp, level_t act);
    if (act !== exp) begin
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      stop_fail("value mismatch");
    end
  endtask

  task automatic check_sel(string name, pc_sel_t exp, pc_sel_t act);
    if (act !== exp) begin
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      stop_fail("value mismatch");
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      stop_fail("value mismatch");
    end
  endtask

  function automatic csr_word_t model_op(csr_word_t cur, csr_word_t opnd, csr_op_t op);
    case (op)
      csr_write: return opnd;
      csr_set:   return cur | opnd;
      csr_clear: return cur & ~opnd;
      default:   return cur;
    endcase
  endfunction

  function automatic csr_word_t model_read(csr_addr_t a);
    int vi;
    int ei;
    vi = int'(a) - int'(vec_csr_base);
    ei = int'(a) - int'(entry_csr_base);
    if (a == int_thresh_addr) return csr_word_t'(m_thresh);
    if (vi >= 0 && vi < vec_size) return csr_word_t'(m_vec[vi]);
    if (ei >= 0 && ei < vec_size) return csr_word_t'(m_entry[ei].bits);
    return '0;
  endfunction

  // max live priority first, then the lowest index holding it
  task automatic find_winner(output logic found, output prio_t best, output int idx);
    logic seen;
    seen = 1'b0;
    best = '0;
    idx = 0;
    for (int k = 0; k < vec_size; k++) begin
      if (m_entry[k].fields.enabled && m_entry[k].fields.pended) begin
        if (!seen || m_entry[k].fields.prio > best) best = m_entry[k].fields.prio;
        seen = 1'b1;
      end
    end
    for (int k = vec_size - 1; k >= 0; k--) begin
      if (m_entry[k].fields.enabled && m_entry[k].fields.pended &&
          m_entry[k].fields.prio == best) idx = k;
    end
    found = seen && best > m_thresh;
  endtask

  // state change at a rising edge, from the inputs applied before it
  task automatic model_edge();
    logic found;
    prio_t best;
    int idx;
    int d;
    int vi;
    int ei;
    logic thresh_busy;
    csr_word_t opnd;
    find_winner(found, best, idx);
    d = int'(m_depth);
    vi = int'(csr_addr) - int'(vec_csr_base);
    ei = int'(csr_addr) - int'(entry_csr_base);
    thresh_busy = 1'b0;
    opnd = csr_op[1] ? csr_word_t'(rs1_zimm) : rs1_data;
    if (found && pc_in != '1) begin
      if (d < stack_depth) begin
        m_stk_addr[d] = pc_in;
        m_stk_prio[d] = m_thresh;
        m_depth = level_t'(d + 1);
      end
      m_thresh = best;
      thresh_busy = 1'b1;
    end else if (!found && pc_in == '1) begin
      m_thresh = (d == 0) ? '0 : m_stk_prio[d-1];
      thresh_busy = 1'b1;
      if (d > 0) m_depth = level_t'(d - 1);
    end
    if (csr_enable) begin
      if (csr_addr == int_thresh_addr && !thresh_busy) begin
        m_thresh = prio_t'(model_op(csr_word_t'(m_thresh), opnd, csr_op));
      end
      if (vi >= 0 && vi < vec_size) begin
        m_vec[vi] = vec_word_t'(model_op(csr_word_t'(m_vec[vi]), opnd, csr_op));
      end
      if (ei >= 0 && ei < vec_size) begin
        m_entry[ei].bits = 5'(model_op(csr_word_t'(m_entry[ei].bits), opnd, csr_op));
      end
    end
    if (found) m_entry[idx].fields.pended = 1'b0;
    for (int k = 0; k < vec_size; k++) begin
      if (irq[k]) m_entry[k].fields.pended = 1'b1;
    end
  endtask

  task automatic check_outputs();
    logic found;
    prio_t best;
    int idx;
    int d;
    imem_addr_t exp_addr;
    pc_sel_t exp_sel;
    find_winner(found, best, idx);
    d = int'(m_depth);
    exp_addr = pc_in;
    exp_sel = pc_normal;
    if (found) begin
      exp_addr = {m_vec[idx], 2'b00};
      exp_sel = pc_interrupt;
    end else if (pc_in == '1) begin
      exp_addr = (d == 0) ? '0 : m_stk_addr[d-1];
      exp_sel = pc_interrupt;
    end
    check_word("csr_out", model_read(csr_addr), csr_out);
    check_addr("int_addr", exp_addr, int_addr);
    check_sel("pc_interrupt_sel", exp_sel, pc_interrupt_sel);
    check_flag("interrupt_out", found, interrupt_out);
    check_level("level_out", m_depth, level_out);
  endtask

  // one clock: update model, drive inputs, check at the falling edge
  task automatic run_cycle(logic en, csr_addr_t addr, csr_op_t op, zimm_t zimm,
                           csr_word_t data, logic [vec_size-1:0] lines, imem_addr_t pc);
    @(posedge clk);
    model_edge();
    csr_enable <= en;
    csr_addr <= addr;
    csr_op <= op;
    rs1_zimm <= zimm;
    rs1_data <= data;
    irq <= lines;
    pc_in <= pc;
    @(negedge clk);
    check_outputs();
  endtask

  initial begin
    #(clk_period * total_cycles * 2);
    $display("timeout, the test did not reach its end in time");
    stop_fail("watchdog expired");
  end

  initial begin
    csr_addr_t a;
    logic [vec_size-1:0] lines;
    imem_addr_t pc;
    rst_n = 1'b0;
    csr_enable = 1'b0;
    csr_addr = '0;
    csr_op = csr_write;
    rs1_zimm = '0;
    rs1_data = '0;
    irq = '0;
    pc_in = '0;
    lfsr = 16'd6470;
    m_thresh = '0;
    m_depth = '0;
    for (int k = 0; k < vec_size; k++) begin
      m_vec[k] = '0;
      m_entry[k] = '0;
    end
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;

    // csr access, each followed by a read of the same address
    for (int n = 0; n < csr_pairs; n++) begin
      a = rand_addr();
      run_cycle(1'b1, a, rand_op(), zimm_t'(rand_bits(5)), rand_bits(32), '0, rand_pc());
      run_cycle(1'b0, a, csr_write, '0, '0, '0, rand_pc());
    end

    // random handlers and entries, then arbitration under sparse irqs
    for (int k = 0; k < vec_size; k++) begin
      run_cycle(1'b1, vec_csr_base + csr_addr_t'(k), csr_write, '0, rand_bits(32), '0,
                rand_pc());
      run_cycle(1'b1, entry_csr_base + csr_addr_t'(k), csr_write, '0, rand_bits(32), '0,
                rand_pc());
    end
    for (int n = 0; n < arb_cycles; n++) begin
      lines = vec_size'(rand_bits(vec_size) & rand_bits(vec_size));
      run_cycle(rand_bits(3) == 0, int_thresh_addr, csr_write, '0, rand_bits(32), lines,
                rand_pc());
    end

    // takes, returns and tail-chains mixed with csr traffic
    for (int n = 0; n < mix_cycles; n++) begin
      lines = vec_size'(rand_bits(vec_size) & rand_bits(vec_size));
      pc = (rand_bits(2) == 0) ? '1 : rand_pc();
      run_cycle(rand_bits(2) == 0, rand_addr(), rand_op(), zimm_t'(rand_bits(5)),
                rand_bits(32), lines, pc);
    end

    // only the top vector live, at priority 7
    for (int k = 0; k < vec_size; k++) begin
      run_cycle(1'b1, entry_csr_base + csr_addr_t'(k), csr_write, '0,
                (k == vec_size - 1) ? 32'h1e : 32'h0, '0, rand_pc());
    end
    // drop the threshold and raise the line, so each round nests once more
    for (int n = 0; n < nest_rounds; n++) begin
      run_cycle(1'b1, int_thresh_addr, csr_write, '0, '0, top_irq, rand_pc());
      run_cycle(1'b0, int_thresh_addr, csr_write, '0, '0, '0, rand_pc());
    end
    check_level("level_out", level_t'(stack_depth), level_out);
    for (int n = 0; n < nest_rounds; n++) begin
      run_cycle(1'b0, int_thresh_addr, csr_write, '0, '0, '0, '1);
    end
    check_level("level_out", '0, level_out);

    // one level deep, then a return that finds the top vector pending again
    run_cycle(1'b0, int_thresh_addr, csr_write, '0, '0, top_irq, rand_pc());
    run_cycle(1'b0, int_thresh_addr, csr_write, '0, '0, '0, rand_pc());
    run_cycle(1'b1, int_thresh_addr, csr_write, '0, '0, top_irq, rand_pc());
    run_cycle(1'b0, int_thresh_addr, csr_write, '0, '0, '0, '1);
    check_flag("interrupt_out", 1'b1, interrupt_out);
    run_cycle(1'b0, int_thresh_addr, csr_write, '0, '0, '0, rand_pc());
    check_level("level_out", level_t'(1), level_out);

    $display("TEST PASS");
    $finish;
  end

endmodule

/* build.f */
hw/clic_pkg.sv
hw/clic_csr_bank.sv
hw/clic_epc_stack.sv
hw/clic_dispatch.sv
hw/clic_top.sv
bench/clic_tb.sv

/* hw/clic_csr_bank.sv */
// clic csr bank
`timescale 1ns/1ns

module clic_csr_bank #(
  parameter int vec_size = 8,
  localparam int idx_width = (vec_size > 1) ? $clog2(vec_size) : 1
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   csr_enable,
  input  clic_pkg::csr_addr_t                    csr_addr,
  input  clic_pkg::csr_op_t                      csr_op,
  input  clic_pkg::zimm_t                        rs1_zimm,
  input  clic_pkg::csr_word_t                    rs1_data,
  input  logic [vec_size-1:0]                    irq,
  input  logic                                   thresh_we,
  input  clic_pkg::prio_t                        thresh_next,
  input  logic                                   take,
  input  logic [idx_width-1:0]                   take_idx,
  output clic_pkg::csr_word_t                    csr_out,
  output clic_pkg::prio_t                        thresh,
  output clic_pkg::vec_word_t [vec_size-1:0]     vec_table,
  output clic_pkg::entry_t [vec_size-1:0]        entry_table
);
  import clic_pkg::*;

  csr_word_t operand;
  prio_t     thresh_d;
  vec_word_t [vec_size-1:0] vec_d;
  entry_t [vec_size-1:0]    entry_d;

  // read-modify-write on the full word, caller keeps its own width
  function automatic csr_word_t apply_op(csr_word_t cur, csr_word_t opnd, csr_op_t op);
    case (op)
      csr_write: apply_op = opnd;
      csr_set:   apply_op = cur | opnd;
      csr_clear: apply_op = cur & ~opnd;
      default:   apply_op = cur;
    endcase
  endfunction

  // immediate form zero-extends the 5-bit field
  assign operand = csr_op[1] ? csr_word_t'(rs1_zimm) : rs1_data;

  // threshold, dispatch write ahead of csr access
  always_comb begin
    thresh_d = thresh;
    if (thresh_we) begin
      thresh_d = thresh_next;
    end else if (csr_enable && csr_addr == int_thresh_addr) begin
      thresh_d = prio_t'(apply_op(csr_word_t'(thresh), operand, csr_op));
    end
  end

  // vector and entry tables
  always_comb begin
    vec_d   = vec_table;
    entry_d = entry_table;
    for (int k = 0; k < vec_size; k++) begin
      if (csr_enable && csr_addr == csr_addr_t'(vec_csr_base + k)) begin
        vec_d[k] = vec_word_t'(apply_op(csr_word_t'(vec_table[k]), operand, csr_op));
      end
      if (csr_enable && csr_addr == csr_addr_t'(entry_csr_base + k)) begin
        entry_d[k].bits = 5'(apply_op(csr_word_t'(entry_table[k].bits), operand, csr_op));
      end
      // taken vector drops pending, a live irq line sets it again
      if (take && take_idx == idx_width'(k)) begin
        entry_d[k].fields.pended = 1'b0;
      end
      if (irq[k]) begin
        entry_d[k].fields.pended = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      thresh      <= '0;
      vec_table   <= '0;
      entry_table <= '0;
    end else begin
      thresh      <= thresh_d;
      vec_table   <= vec_d;
      entry_table <= entry_d;
    end
  end

  // read mux, unmapped reads as zero
  always_comb begin
    csr_out = '0;
    if (csr_addr == int_thresh_addr) begin
      csr_out = csr_word_t'(thresh);
    end
    for (int k = 0; k < vec_size; k++) begin
      if (csr_addr == csr_addr_t'(vec_csr_base + k)) begin
        csr_out = csr_word_t'(vec_table[k]);
      end
      if (csr_addr == csr_addr_t'(entry_csr_base + k)) begin
        csr_out = csr_word_t'(entry_table[k].bits);
      end
    end
  end

endmodule

/* hw/clic_dispatch.sv */
// clic interrupt dispatch
`timescale 1ns/1ns

module clic_dispatch #(
  parameter int vec_size = 8,
  localparam int idx_width = (vec_size > 1) ? $clog2(vec_size) : 1
) (
  input  clic_pkg::imem_addr_t               pc_in,
  input  clic_pkg::prio_t                    thresh,
  input  clic_pkg::vec_word_t [vec_size-1:0] vec_table,
  input  clic_pkg::entry_t [vec_size-1:0]    entry_table,
  input  clic_pkg::imem_addr_t               top_addr,
  input  clic_pkg::prio_t                    top_prio,
  output logic                               push,
  output logic                               pop,
  output clic_pkg::imem_addr_t               push_addr,
  output clic_pkg::prio_t                    push_prio,
  output logic                               thresh_we,
  output clic_pkg::prio_t                    thresh_next,
  output logic                               take,
  output logic [idx_width-1:0]               take_idx,
  output clic_pkg::imem_addr_t               int_addr,
  output clic_pkg::pc_sel_t                  pc_interrupt_sel,
  output logic                               interrupt_out
);
  import clic_pkg::*;

  logic                 found;
  prio_t                best_prio;
  logic [idx_width-1:0] best_idx;
  logic                 is_ret;
  imem_addr_t           handler;

  // chained search, strict compare keeps the lowest index on a tie
  always_comb begin
    found     = 1'b0;
    best_prio = thresh;
    best_idx  = '0;
    for (int k = 0; k < vec_size; k++) begin
      if (entry_table[k].fields.enabled && entry_table[k].fields.pended &&
          entry_table[k].fields.prio > best_prio) begin
        found     = 1'b1;
        best_prio = entry_table[k].fields.prio;
        best_idx  = idx_width'(k);
      end
    end
  end

  // all-ones pc marks a return from interrupt
  assign is_ret  = pc_in == '1;
  assign handler = {vec_table[best_idx], 2'b00};

  // the stack saves the interrupted pc with the old threshold
  assign push_addr = pc_in;
  assign push_prio = thresh;
  assign take_idx  = best_idx;

  always_comb begin
    push             = 1'b0;
    pop              = 1'b0;
    thresh_we        = 1'b0;
    thresh_next      = best_prio;
    take             = 1'b0;
    int_addr         = pc_in;
    pc_interrupt_sel = pc_normal;
    interrupt_out    = 1'b0;
    if (found) begin
      // tail-chain leaves stack and threshold alone
      take             = 1'b1;
      int_addr         = handler;
      pc_interrupt_sel = pc_interrupt;
      interrupt_out    = 1'b1;
      if (!is_ret) begin
        push      = 1'b1;
        thresh_we = 1'b1;
      end
    end else if (is_ret) begin
      pop              = 1'b1;
      thresh_we        = 1'b1;
      thresh_next      = top_prio;
      int_addr         = top_addr;
      pc_interrupt_sel = pc_interrupt;
    end
  end

endmodule

/* hw/clic_epc_stack.sv */
// clic return address stack
`timescale 1ns/1ns

module clic_epc_stack (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 push,
  input  logic                 pop,
  input  clic_pkg::imem_addr_t push_addr,
  input  clic_pkg::prio_t      push_prio,
  output clic_pkg::imem_addr_t top_addr,
  output clic_pkg::prio_t      top_prio,
  output clic_pkg::level_t     depth
);
  import clic_pkg::*;

  localparam int ptr_width = $clog2(stack_depth);

  imem_addr_t addr_mem [stack_depth];
  prio_t      prio_mem [stack_depth];

  logic full;
  logic empty;
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] top_ptr;

  assign full    = depth == level_t'(stack_depth);
  assign empty   = depth == '0;
  assign wr_ptr  = depth[ptr_width-1:0];
  assign top_ptr = ptr_width'(depth - level_t'(1));

  // depth saturates at both ends
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      depth <= '0;
    end else if (push && !full) begin
      depth <= depth + level_t'(1);
    end else if (pop && !empty) begin
      depth <= depth - level_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (push && !full) begin
      addr_mem[wr_ptr] <= push_addr;
      prio_mem[wr_ptr] <= push_prio;
    end
  end

  // empty stack reads back zeros
  assign top_addr = empty ? '0 : addr_mem[top_ptr];
  assign top_prio = empty ? '0 : prio_mem[top_ptr];

endmodule

/* hw/clic_pkg.sv */
// clic shared types
package clic_pkg;

  // csr access
  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_word_t;
  typedef logic [4:0] zimm_t;

  // low two bits of the riscv funct3, the top bit marks the immediate form
  typedef enum logic [1:0] {
    csr_write = 2'b01,
    csr_set   = 2'b10,
    csr_clear = 2'b11
  } csr_op_t;

  // instruction memory byte address
  parameter int imem_addr_width = 16;
  typedef logic [imem_addr_width-1:0] imem_addr_t;

  // handler word address held in a vector csr
  typedef logic [imem_addr_width-3:0] vec_word_t;

  // priority and nesting
  typedef logic [2:0] prio_t;
  typedef logic [3:0] level_t;
  localparam int stack_depth = 2 ** $bits(prio_t);

  // entry csr decoded as fields
  typedef struct packed {
    prio_t prio;
    logic  enabled;
    logic  pended;
  } entry_fields_t;

  // same word, raw for csr ops and decoded for dispatch
  typedef union packed {
    logic [4:0]    bits;
    entry_fields_t fields;
  } entry_t;

  typedef enum logic {
    pc_normal,
    pc_interrupt
  } pc_sel_t;

  // csr map
  localparam csr_addr_t int_thresh_addr = 12'h347;
  localparam csr_addr_t vec_csr_base    = 12'hb00;
  localparam csr_addr_t entry_csr_base  = 12'hb20;

endpackage

/* hw/clic_top.sv */
// clic top level
`timescale 1ns/1ns

module clic_top #(
  parameter int vec_size = 8,
  localparam int idx_width = (vec_size > 1) ? $clog2(vec_size) : 1
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 csr_enable,
  input  clic_pkg::csr_addr_t  csr_addr,
  input  clic_pkg::csr_op_t    csr_op,
  input  clic_pkg::zimm_t      rs1_zimm,
  input  clic_pkg::csr_word_t  rs1_data,
  input  logic [vec_size-1:0]  irq,
  input  clic_pkg::imem_addr_t pc_in,
  output clic_pkg::csr_word_t  csr_out,
  output clic_pkg::imem_addr_t int_addr,
  output clic_pkg::pc_sel_t    pc_interrupt_sel,
  output clic_pkg::level_t     level_out,
  output logic                 interrupt_out
);
  import clic_pkg::*;

  // bank to dispatch
  prio_t                    thresh;
  vec_word_t [vec_size-1:0] vec_table;
  entry_t [vec_size-1:0]    entry_table;

  // dispatch to bank
  logic                 thresh_we;
  prio_t                thresh_next;
  logic                 take;
  logic [idx_width-1:0] take_idx;

  // dispatch and stack
  logic       push;
  logic       pop;
  imem_addr_t push_addr;
  prio_t      push_prio;
  imem_addr_t top_addr;
  prio_t      top_prio;

  clic_csr_bank #(
    .vec_size(vec_size)
  ) u_csr_bank (
    .clk, .rst_n, .csr_enable, .csr_addr, .csr_op, .rs1_zimm, .rs1_data, .irq,
    .thresh_we, .thresh_next, .take, .take_idx,
    .csr_out, .thresh, .vec_table, .entry_table
  );

  clic_epc_stack u_epc_stack (
    .clk, .rst_n, .push, .pop, .push_addr, .push_prio,
    .top_addr, .top_prio,
    .depth(level_out)
  );

  clic_dispatch #(
    .vec_size(vec_size)
  ) u_dispatch (
    .pc_in, .thresh, .vec_table, .entry_table, .top_addr, .top_prio,
    .push, .pop, .push_addr, .push_prio, .thresh_we, .thresh_next, .take, .take_idx,
    .int_addr, .pc_interrupt_sel, .interrupt_out
  );

endmodule
